/* i2c_target_pkg.sv */
// i2c target receive package
// shared constants, FSM state encoding and the two views of a received byte
package i2c_target_pkg;

    // identical samples needed before a filtered level moves
    localparam int unsigned filter_len = 4;

    // 7-bit addressing only
    localparam int unsigned addr_width = 7;
    localparam int unsigned byte_width = 8;

    // bit counter load value, counts down to zero over one byte
    localparam logic [2:0] bit_count_max = 3'd7;

    // receive FSM states
    typedef enum logic [2:0] {
        st_idle,
        st_address,
        st_ack,
        st_write_wait,
        st_write_shift
    } rx_state_t;

    // received shift byte
    // first byte after start is address plus rw, later bytes are data
    typedef union packed {
        logic [byte_width-1:0] data;
        struct packed {
            logic [addr_width-1:0] addr;
            logic                  rw;
        } frame;
    } rx_byte_u;

endpackage

/* i2c_line_if.sv */
// filtered i2c line events
// levels and one-cycle edge and condition pulses from the line front end
interface i2c_line_if;

    // filtered levels, aligned with the pulses below
    logic scl;
    logic sda;

    // single cycle pulses
    logic scl_rise;
    logic scl_fall;
    logic start;
    logic stop;

    // line front end drives everything
    modport src (
        output scl, sda, scl_rise, scl_fall, start, stop
    );

    // receive FSM only listens
    modport dst (
        input scl, sda, scl_rise, scl_fall, start, stop
    );

endinterface

/* i2c_line_sync.sv */
// i2c line front end
// glitch filters raw SCL and SDA, finds SCL edges and start/stop conditions
// and tracks whether any controller currently owns the bus
module i2c_line_sync import i2c_target_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    scl_i,
    input  logic    sda_i,
    i2c_line_if.src line,
    output logic    bus_active
);

    // raw sample history, newest in bit 0
    logic [filter_len-1:0] scl_hist;
    logic [filter_len-1:0] sda_hist;

    // filtered levels
    logic scl_filt;
    logic sda_filt;

    // filtered levels one cycle later, used for edges
    logic scl_prev;
    logic sda_prev;

    // registered event pulses
    logic scl_rise_q;
    logic scl_fall_q;
    logic start_q;
    logic stop_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            // idle bus reads high on both lines
            scl_hist   <= '1;
            sda_hist   <= '1;
            scl_filt   <= 1'b1;
            sda_filt   <= 1'b1;
            scl_prev   <= 1'b1;
            sda_prev   <= 1'b1;
            scl_rise_q <= 1'b0;
            scl_fall_q <= 1'b0;
            start_q    <= 1'b0;
            stop_q     <= 1'b0;
            bus_active <= 1'b0;
        end else begin
            scl_hist <= {scl_hist[filter_len-2:0], scl_i};
            sda_hist <= {sda_hist[filter_len-2:0], sda_i};

            // level moves only once the whole history agrees
            if (&scl_hist) begin
                scl_filt <= 1'b1;
            end else if (~|scl_hist) begin
                scl_filt <= 1'b0;
            end
            if (&sda_hist) begin
                sda_filt <= 1'b1;
            end else if (~|sda_hist) begin
                sda_filt <= 1'b0;
            end

            scl_prev <= scl_filt;
            sda_prev <= sda_filt;

            scl_rise_q <= scl_filt && !scl_prev;
            scl_fall_q <= !scl_filt && scl_prev;

            // sda edges while scl high are conditions, not data
            start_q <= !sda_filt && sda_prev && scl_filt;
            stop_q  <= sda_filt && !sda_prev && scl_filt;

            if (start_q) begin
                bus_active <= 1'b1;
            end else if (stop_q) begin
                bus_active <= 1'b0;
            end
        end
    end

    // delayed levels so sda is valid alongside scl_rise
    assign line.scl      = scl_prev;
    assign line.sda      = sda_prev;
    assign line.scl_rise = scl_rise_q;
    assign line.scl_fall = scl_fall_q;
    assign line.start    = start_q;
    assign line.stop     = stop_q;

endmodule

/* i2c_rx_fsm.sv */
// i2c target receive FSM
// matches the address under a mask, ACKs write transfers and pushes data
// bytes onto a valid/ready stream one byte late so the last one is marked
// stretches SCL while the stream output is still full
module i2c_rx_fsm import i2c_target_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    i2c_line_if.dst               line,
    input  logic                  enable,
    input  logic [addr_width-1:0] device_address,
    input  logic [addr_width-1:0] device_address_mask,
    output logic [byte_width-1:0] m_data,
    output logic                  m_last,
    output logic                  m_valid,
    input  logic                  m_ready,
    output logic                  scl_o,
    output logic                  sda_o,
    output logic [addr_width-1:0] bus_address,
    output logic                  bus_addressed
);

    rx_state_t state;
    rx_state_t state_next;

    logic [$bits(bit_count_max)-1:0] bit_count;
    logic [$bits(bit_count_max)-1:0] bit_count_next;

    // shift register and its value with the current sda bit appended
    rx_byte_u shift_byte;
    rx_byte_u shift_next;
    rx_byte_u in_byte;

    // complete byte sitting in the shift register
    logic byte_full;
    logic byte_full_next;

    // m_data holds a byte not yet released
    logic held_valid;
    logic held_next;

    logic [byte_width-1:0] m_data_next;
    logic                  m_last_next;
    logic                  m_valid_next;
    logic                  scl_o_next;
    logic                  sda_o_next;
    logic [addr_width-1:0] bus_address_next;
    logic                  bus_addressed_next;
    logic                  addr_match;

    // msb first on the wire
    assign in_byte.data = {shift_byte.data[byte_width-2:0], line.sda};

    // only masked-in bits compare, read requests never match
    assign addr_match = enable && !in_byte.frame.rw &&
        (((in_byte.frame.addr ^ device_address) & device_address_mask) == '0);

    always_comb begin
        state_next         = state;
        bit_count_next     = bit_count;
        shift_next         = shift_byte;
        byte_full_next     = byte_full;
        held_next          = held_valid;
        m_data_next        = m_data;
        m_last_next        = m_last;
        m_valid_next       = m_valid && !m_ready;
        scl_o_next         = scl_o;
        sda_o_next         = sda_o;
        bus_address_next   = bus_address;
        bus_addressed_next = bus_addressed;

        if (line.start || line.stop) begin
            // end of transfer, held byte goes out as the last one
            if (held_valid) begin
                m_valid_next = 1'b1;
                m_last_next  = 1'b1;
            end
            held_next          = 1'b0;
            byte_full_next     = 1'b0;
            bus_addressed_next = 1'b0;
            scl_o_next         = 1'b1;
            sda_o_next         = 1'b1;
            bit_count_next     = bit_count_max;
            state_next         = line.start ? st_address : st_idle;
        end else begin
            case (state)
                st_idle: begin
                    held_next          = 1'b0;
                    byte_full_next     = 1'b0;
                    bus_addressed_next = 1'b0;
                end
                st_address: begin
                    if (line.scl_rise) begin
                        shift_next = in_byte;
                        if (bit_count != '0) begin
                            bit_count_next = bit_count - 1'b1;
                        end else if (addr_match) begin
                            bus_address_next   = in_byte.frame.addr;
                            bus_addressed_next = 1'b1;
                            state_next         = st_ack;
                        end else begin
                            // not ours, stay off the bus
                            state_next = st_idle;
                        end
                    end
                end
                st_ack: begin
                    // pull sda low for the ninth clock
                    if (line.scl_fall) begin
                        sda_o_next     = 1'b0;
                        bit_count_next = bit_count_max;
                        state_next     = st_write_wait;
                    end
                end
                st_write_wait: begin
                    // end of ack clock, or still holding scl low
                    if (line.scl_fall || (!line.scl && !scl_o)) begin
                        sda_o_next = 1'b1;
                        if (m_valid && !m_ready) begin
                            // output still full
                            scl_o_next = 1'b0;
                        end else begin
                            scl_o_next = 1'b1;
                            // move finished byte into the hold slot
                            if (byte_full) begin
                                m_data_next = shift_byte.data;
                                m_last_next = 1'b0;
                            end
                            held_next      = byte_full;
                            byte_full_next = 1'b0;
                            state_next     = st_write_shift;
                        end
                    end
                end
                st_write_shift: begin
                    if (line.scl_rise) begin
                        shift_next = in_byte;
                        if (bit_count != '0) begin
                            bit_count_next = bit_count - 1'b1;
                        end else begin
                            // another byte followed, so the held one is not last
                            if (held_valid) begin
                                m_valid_next = 1'b1;
                            end
                            held_next      = 1'b0;
                            byte_full_next = 1'b1;
                            state_next     = st_ack;
                        end
                    end
                end
                default: begin
                    state_next = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= st_idle;
            bit_count     <= bit_count_max;
            byte_full     <= 1'b0;
            held_valid    <= 1'b0;
            m_valid       <= 1'b0;
            scl_o         <= 1'b1;
            sda_o         <= 1'b1;
            bus_addressed <= 1'b0;
        end else begin
            state         <= state_next;
            bit_count     <= bit_count_next;
            byte_full     <= byte_full_next;
            held_valid    <= held_next;
            m_valid       <= m_valid_next;
            scl_o         <= scl_o_next;
            sda_o         <= sda_o_next;
            bus_addressed <= bus_addressed_next;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        shift_byte  <= shift_next;
        m_data      <= m_data_next;
        m_last      <= m_last_next;
        bus_address <= bus_address_next;
    end

endmodule

/* i2c_target_rx.sv */
// receive-only i2c target
// write transfers to a masked 7-bit address come out as a byte stream
// with the final byte marked, open-drain outputs are high when released
module i2c_target_rx import i2c_target_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  scl_o,
    output logic                  sda_o,
    input  logic                  enable,
    input  logic [addr_width-1:0] device_address,
    input  logic [addr_width-1:0] device_address_mask,
    output logic [byte_width-1:0] m_data,
    output logic                  m_last,
    output logic                  m_valid,
    input  logic                  m_ready,
    output logic                  bus_active,
    output logic                  bus_addressed,
    output logic [addr_width-1:0] bus_address
);

    // filtered line events between front end and FSM
    i2c_line_if line_bus ();

    i2c_line_sync i_line_sync (
        .clk        (clk),
        .rst        (rst),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .line       (line_bus.src),
        .bus_active (bus_active)
    );

    i2c_rx_fsm i_rx_fsm (
        .clk                 (clk),
        .rst                 (rst),
        .line                (line_bus.dst),
        .enable              (enable),
        .device_address      (device_address),
        .device_address_mask (device_address_mask),
        .m_data              (m_data),
        .m_last              (m_last),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .scl_o               (scl_o),
        .sda_o               (sda_o),
        .bus_address         (bus_address),
        .bus_addressed       (bus_addressed)
    );

endmodule

/* i2c_target_rx_assertions.sv */
// bound checks on the receive target's ports
// released lines after reset, stream hold rules, status consistency
module i2c_target_rx_assertions import i2c_target_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  sda_i,
    input logic                  scl_o,
    input logic                  sda_o,
    input logic [byte_width-1:0] m_data,
    input logic                  m_last,
    input logic                  m_valid,
    input logic                  m_ready,
    input logic                  bus_active,
    input logic                  bus_addressed
);
    timeunit 1ns;
    timeprecision 1ps;

    // running count of failed properties
    int unsigned failures = 0;

    // both open-drain outputs come out of reset released
    assert property (@(posedge clk) rst |=> scl_o && sda_o)
        else begin
            $error("scl_o or sda_o driven low right after reset");
            failures++;
        end

    // offered beat stays put until taken
    assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
        else begin
            $error("stream beat changed or dropped before it was taken");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst) !(bus_addressed && !bus_active))
        else begin
            $error("bus_addressed high while the bus is idle");
            failures++;
        end

    // a start needs sda low through a full filter window
    assert property (@(posedge clk) disable iff (rst)
        $rose(bus_active) |-> !$past(sda_i, filter_len))
        else begin
            $error("bus became active without a filtered start");
            failures++;
        end

endmodule

bind i2c_target_rx i2c_target_rx_assertions i_assertions (.*);

/* tb_i2c_target_rx.sv */
// testbench for the receive-only i2c target
// a controller model writes frames over a wired-AND bus, a reference
// function predicts ACKs and the byte stream, a monitor compares each beat
module tb_i2c_target_rx import i2c_target_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_bit = 20;
    localparam int bit_cycles = 2 * half_bit;
    // 15 bytes over six frames, stall allowance, start/stop/drain per frame
    localparam int cycle_limit = 2 * (15 * 9 * bit_cycles + 400 + 6 * 4 * bit_cycles);

    typedef logic [byte_width-1:0] byte_q_t[$];
    // beat is {last, data}
    typedef logic [byte_width:0] beat_q_t[$];

    logic clk;
    logic rst;
    logic scl_i = 1'b1;
    logic sda_i = 1'b1;
    logic scl_o;
    logic sda_o;
    logic enable;
    logic [addr_width-1:0] device_address;
    logic [addr_width-1:0] device_address_mask;
    logic [byte_width-1:0] m_data;
    logic m_last;
    logic m_valid;
    logic m_ready;
    logic bus_active;
    logic bus_addressed;
    logic [addr_width-1:0] bus_address;
    // controller side of the open-drain lines
    logic model_scl;
    logic model_sda;
    logic stretched;
    beat_q_t exp_q;
    string test_name;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;

    i2c_target_rx i_i2c_target_rx (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // wired-AND bus, one register stage like a pad input
    always @(posedge clk) begin
        scl_i <= model_scl & scl_o;
        sda_i <= model_sda & sda_o;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no progress after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // every accepted beat against the next predicted one
    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                $display("%s: stream gave byte %02h when none was due", test_name, m_data);
                errors++;
            end else begin
                // the final byte is only known once the stop was seen
                if (m_last) begin
                    check_value("last byte after stop", 1'b0, bus_active);
                end
                check_value("stream beat", exp_q.pop_front(), {m_last, m_data});
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // ack rule plus the byte stream a write should produce
    function automatic logic expected_stream(input logic [addr_width-1:0] addr,
                                             input logic rw, input logic en,
                                             input logic [addr_width-1:0] dev,
                                             input logic [addr_width-1:0] mask,
                                             input byte_q_t bytes, output beat_q_t beats);
        logic ack;
        ack = en && !rw && ((addr & mask) == (dev & mask));
        beats = {};
        if (ack) begin
            foreach (bytes[i]) begin
                beats.push_back({(i == bytes.size() - 1), bytes[i]});
            end
        end
        return ack;
    endfunction

    function automatic byte_q_t random_bytes(input int n);
        byte_q_t q;
        repeat (n) begin
            q.push_back(8'($urandom));
        end
        return q;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // let scl go and wait for the bus, a stretching target holds it low
    task automatic release_scl();
        int waited = 0;
        @(posedge clk);
        model_scl <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (scl_i !== 1'b1);
        if (waited > 3) begin
            stretched = 1'b1;
        end
    endtask

    // one clock with sda set up early in the low half
    task automatic send_bit(input logic b);
        wait_cycles(half_bit / 4);
        model_sda <= b;
        wait_cycles(half_bit - half_bit / 4);
        release_scl();
        wait_cycles(half_bit);
        model_scl <= 1'b0;
    endtask

    task automatic send_byte(input logic [byte_width-1:0] value, output logic ack);
        for (int i = byte_width - 1; i >= 0; i--) begin
            send_bit(value[i]);
        end
        // ninth clock, sda left to the target
        wait_cycles(half_bit / 4);
        model_sda <= 1'b1;
        wait_cycles(half_bit - half_bit / 4);
        release_scl();
        wait_cycles(half_bit);
        ack = !sda_i;
        model_scl <= 1'b0;
    endtask

    task automatic send_start();
        wait_cycles(half_bit);
        model_sda <= 1'b0;
        wait_cycles(half_bit);
        model_scl <= 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(half_bit / 4);
        model_sda <= 1'b0;
        wait_cycles(half_bit - half_bit / 4);
        release_scl();
        wait_cycles(half_bit);
        model_sda <= 1'b1;
        wait_cycles(half_bit);
    endtask

    task automatic configure(input logic en, input logic [addr_width-1:0] mask);
        @(posedge clk);
        enable <= en;
        device_address_mask <= mask;
        @(posedge clk);
    endtask

    // hold the stream off once the first byte is offered
    task automatic stall_stream(input int n);
        @(posedge clk);
        m_ready <= 1'b0;
        do begin
            @(posedge clk);
        end while (!m_valid);
        wait_cycles(n);
        m_ready <= 1'b1;
    endtask

    task automatic run_write(input string name, input logic [addr_width-1:0] addr,
                             input logic rw, input byte_q_t bytes, input logic expect_stretch);
        rx_byte_u first;
        logic ack;
        logic ack_exp;
        int errors_before;
        int n;
        errors_before = errors;
        test_name = name;
        stretched = 1'b0;
        ack_exp = expected_stream(addr, rw, enable, device_address, device_address_mask,
                                  bytes, exp_q);
        first.frame.addr = addr;
        first.frame.rw = rw;
        send_start();
        send_byte(first.data, ack);
        check_value("address ack", ack_exp, ack);
        check_value("bus_active", 1'b1, bus_active);
        check_value("bus_addressed", ack_exp, bus_addressed);
        if (ack) begin
            check_value("bus_address", addr, bus_address);
            foreach (bytes[i]) begin
                send_byte(bytes[i], ack);
                check_value("data ack", 1'b1, ack);
            end
        end
        send_stop();
        check_value("bus_active after stop", 1'b0, bus_active);
        check_value("bus_addressed after stop", 1'b0, bus_addressed);
        check_value("scl stretched", expect_stretch, stretched);
        // last byte only leaves after the stop
        n = 0;
        while (exp_q.size() != 0 && n < 4 * bit_cycles) begin
            @(posedge clk);
            n++;
        end
        wait_cycles(bit_cycles);
        if (exp_q.size() != 0) begin
            $display("%s: %0d stream bytes never arrived", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        tests++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        void'($urandom(8));
        rst = 1'b1;
        model_scl = 1'b1;
        model_sda = 1'b1;
        enable = 1'b1;
        device_address = 7'h2a;
        device_address_mask = '1;
        m_ready = 1'b1;
        wait_cycles(2);
        rst <= 1'b0;
        wait_cycles(bit_cycles);
        run_write("exact address", 7'h2a, 1'b0, random_bytes(4), 1'b0);
        run_write("address mismatch", 7'h2b, 1'b0, random_bytes(1), 1'b0);
        configure(1'b0, '1);
        run_write("target disabled", 7'h2a, 1'b0, random_bytes(1), 1'b0);
        configure(1'b1, '1);
        run_write("read request", 7'h2a, 1'b1, random_bytes(1), 1'b0);
        // low two address bits ignored
        configure(1'b1, 7'h7c);
        run_write("masked address", 7'h29, 1'b0, random_bytes(2), 1'b0);
        configure(1'b1, '1);
        fork
            run_write("stretched stream", 7'h2a, 1'b0, random_bytes(3), 1'b1);
            stall_stream(200);
        join
        errors += i_i2c_target_rx.i_assertions.failures;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* project.f */
i2c_target_pkg.sv
i2c_line_if.sv
i2c_line_sync.sv
i2c_rx_fsm.sv
i2c_target_rx.sv
i2c_target_rx_assertions.sv
tb_i2c_target_rx.sv

/* Bender.yml */
package:
  name: i2c_target_rx

sources:
  - i2c_target_pkg.sv
  - i2c_line_if.sv
  - i2c_line_sync.sv
  - i2c_rx_fsm.sv
  - i2c_target_rx.sv
  - target: test
    files:
      - i2c_target_rx_assertions.sv
      - tb_i2c_target_rx.sv
